// ==== hdl/decode_consts.svh ====
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// ========================================
// Field widths
// ========================================

// Opcode field of the micro-op
`define DEC_OPC_W 7
// Register number, 64 architectural registers
`define DEC_REG_W 6
// Function field that sits above Rs2
`define DEC_FUNC_W 7
// Immediate is func and rs2 joined together before sign extension
`define DEC_IMM_W 13
// Width of the immediate carried on the decode bus
`define DEC_DATA_W 64
// Instruction pointer width
`define DEC_ADDR_W 32

// ========================================
// Register limits and special values
// ========================================

// First register number that user mode may not touch
`define DEC_USER_REG_LIMIT 48
// First register number that supervisor mode may not touch
`define DEC_SUPV_REG_LIMIT 56
// Function field value that turns a fence into a sync
`define DEC_SYNC_FUNC 127

// ========================================
// Opcode values
// ========================================

`define DEC_OP_NOP   7'd0
`define DEC_OP_ADD   7'd1
`define DEC_OP_ADDI  7'd2
`define DEC_OP_AND   7'd3
`define DEC_OP_OR    7'd4
`define DEC_OP_XOR   7'd5
`define DEC_OP_MUL   7'd8
`define DEC_OP_MULU  7'd9
`define DEC_OP_DIV   7'd10
`define DEC_OP_DIVU  7'd11
`define DEC_OP_LOAD  7'd16
`define DEC_OP_STORE 7'd17
`define DEC_OP_BCC   7'd24
`define DEC_OP_JSR   7'd25
`define DEC_OP_BSR   7'd26
`define DEC_OP_FENCE 7'd32
`define DEC_OP_FADD  7'd40
`define DEC_OP_ERET  7'd48
`define DEC_OP_SYS   7'd49

`endif

// ==== hdl/decode_pkg.sv ====
`default_nettype none

`include "decode_consts.svh"

package decode_pkg;

	// ========================================
	// Plain vector types
	// ========================================

	typedef logic [`DEC_OPC_W-1:0]  opcode_t;
	typedef logic [`DEC_REG_W-1:0]  reg_num_t;
	typedef logic [`DEC_FUNC_W-1:0] func_t;
	typedef logic [`DEC_DATA_W-1:0] imm_t;
	typedef logic [`DEC_ADDR_W-1:0] pc_address_t;

	// Privilege level the micro-op runs at
	typedef enum logic [1:0] {
		MODE_USER,
		MODE_SUPV,
		MODE_MACH
	} operating_mode_t;

	// Fault raised by the decoder, carried down the pipe with the micro-op
	typedef enum logic [1:0] {
		FLT_NONE,
		FLT_BADREG,
		FLT_UNIMP
	} fault_cause_t;

	// ========================================
	// Micro-op and decode bus
	// ========================================

	// One valid bit followed by the 32-bit instruction word, opcode in the low bits
	typedef struct packed {
		logic     v;
		func_t    func;
		reg_num_t rs2;
		reg_num_t rs1;
		reg_num_t rd;
		opcode_t  opcode;
	} micro_op_t;

	// Functional unit class flags, more than one may be set at a time
	typedef struct packed {
		logic nop;
		logic alu;
		logic bitwise;
		logic mul;
		logic mulu;
		logic div;
		logic divu;
		logic load;
		logic store;
		logic br;
		logic jsr;
		logic bsr;
		logic fence;
		logic fpu;
		logic eret;
		logic sys;
		// Opcode is in the implemented table
		logic impl;
	} unit_class_t;

	// Everything the later stages need to know about one micro-op
	typedef struct packed {
		logic         v;
		reg_num_t     Rd;
		reg_num_t     Rs1;
		reg_num_t     Rs2;
		logic         Rdz;
		logic         Rs1z;
		logic         Rs2z;
		logic         has_imm;
		logic         has_immb;
		imm_t         imm;
		unit_class_t  cls;
		logic         mem;
		logic         sync;
		logic         rc;
		pc_address_t  ip;
		fault_cause_t cause;
	} decode_bus_t;

endpackage

`default_nettype wire

// ==== hdl/decode_imm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module decode_imm (
	input  decode_pkg::micro_op_t instr,
	output decode_pkg::imm_t      imm,
	output logic                  has_imm,
	output logic                  has_immb
);

	// Raw 13-bit immediate, func sits on top of the rs2 field
	logic [`DEC_IMM_W-1:0] imm_raw;
	// Opcode carries an immediate in place of its second source
	logic                  imm_op;

	assign imm_raw = {instr.func, instr.rs2};

	// ========================================
	// Opcodes with an immediate
	// ========================================

	always_comb begin
		case (instr.opcode)
			`DEC_OP_ADDI,
			`DEC_OP_LOAD,
			`DEC_OP_STORE,
			`DEC_OP_BCC,
			`DEC_OP_FENCE: imm_op = 1'b1;
			default:       imm_op = 1'b0;
		endcase
	end

	// ========================================
	// Sign extension
	// ========================================

	always_comb begin
		if (imm_op) begin
			// Replicate the top bit of the raw field up to the full data width
			imm = {{(`DEC_DATA_W-`DEC_IMM_W){imm_raw[`DEC_IMM_W-1]}}, imm_raw};
		end else begin
			imm = '0;
		end
	end

	// The one immediate this format has always replaces Rs2, so both flags move together
	assign has_imm  = imm_op;
	assign has_immb = imm_op;

endmodule

`default_nettype wire

// ==== hdl/decode_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module decode_regs (
	input  decode_pkg::operating_mode_t om,
	input  decode_pkg::micro_op_t       instr,
	input  logic                        has_immb,
	output decode_pkg::reg_num_t        Rd,
	output decode_pkg::reg_num_t        Rs1,
	output decode_pkg::reg_num_t        Rs2,
	output logic                        Rdz,
	output logic                        Rs1z,
	output logic                        Rs2z,
	output logic                        exc
);

	// Limits are one bit wider than a register number so machine mode can use 64
	localparam logic [`DEC_REG_W:0] lim_user = `DEC_USER_REG_LIMIT;
	localparam logic [`DEC_REG_W:0] lim_supv = `DEC_SUPV_REG_LIMIT;
	localparam logic [`DEC_REG_W:0] lim_mach = 1 << `DEC_REG_W;

	logic [`DEC_REG_W:0] limit;
	logic                uses_rd;
	logic                uses_rs1;
	logic                uses_rs2;
	logic                exc_rd;
	logic                exc_rs1;
	logic                exc_rs2;

	// ========================================
	// Register fields and zero flags
	// ========================================

	assign Rd  = instr.rd;
	assign Rs1 = instr.rs1;
	// The rs2 bits belong to the immediate when one is present
	assign Rs2 = has_immb ? '0 : instr.rs2;

	assign Rdz  = (Rd == '0);
	assign Rs1z = (Rs1 == '0);
	assign Rs2z = (Rs2 == '0);

	// ========================================
	// Legality check against the mode
	// ========================================

	always_comb begin
		case (om)
			decode_pkg::MODE_USER: limit = lim_user;
			decode_pkg::MODE_SUPV: limit = lim_supv;
			decode_pkg::MODE_MACH: limit = lim_mach;
			// Unknown mode encoding gets the tightest limit
			default:               limit = lim_user;
		endcase
	end

	// Work out which fields the opcode really reads or writes
	always_comb begin
		uses_rd  = 1'b1;
		uses_rs1 = 1'b1;
		uses_rs2 = !has_immb;
		case (instr.opcode)
			`DEC_OP_NOP,
			`DEC_OP_ERET,
			`DEC_OP_SYS: begin
				uses_rd  = 1'b0;
				uses_rs1 = 1'b0;
				uses_rs2 = 1'b0;
			end
			// Branches and stores have no destination
			`DEC_OP_BCC,
			`DEC_OP_STORE: uses_rd = 1'b0;
			default: ;
		endcase
	end

	assign exc_rd  = uses_rd  && ({1'b0, instr.rd}  >= limit);
	assign exc_rs1 = uses_rs1 && ({1'b0, instr.rs1} >= limit);
	assign exc_rs2 = uses_rs2 && ({1'b0, instr.rs2} >= limit);

	assign exc = exc_rd | exc_rs1 | exc_rs2;

endmodule

`default_nettype wire

// ==== hdl/decode_class.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module decode_class (
	input  decode_pkg::micro_op_t   instr,
	output decode_pkg::unit_class_t cls
);

	// ========================================
	// Opcode to unit class
	// ========================================

	always_comb begin
		// Start with nothing raised, an opcode outside the table stays that way
		cls = '0;
		case (instr.opcode)
			`DEC_OP_NOP: begin
				cls.nop  = 1'b1;
				cls.impl = 1'b1;
			end
			`DEC_OP_ADD,
			`DEC_OP_ADDI: begin
				cls.alu  = 1'b1;
				cls.impl = 1'b1;
			end
			// Logic ops run on the ALU but are flagged so the scheduler can
			// pick a simpler unit
			`DEC_OP_AND,
			`DEC_OP_OR,
			`DEC_OP_XOR: begin
				cls.alu     = 1'b1;
				cls.bitwise = 1'b1;
				cls.impl    = 1'b1;
			end
			// Multiply and divide keep alu set as well
			`DEC_OP_MUL: begin
				cls.alu  = 1'b1;
				cls.mul  = 1'b1;
				cls.impl = 1'b1;
			end
			`DEC_OP_MULU: begin
				cls.alu  = 1'b1;
				cls.mulu = 1'b1;
				cls.impl = 1'b1;
			end
			`DEC_OP_DIV: begin
				cls.alu  = 1'b1;
				cls.div  = 1'b1;
				cls.impl = 1'b1;
			end
			`DEC_OP_DIVU: begin
				cls.alu  = 1'b1;
				cls.divu = 1'b1;
				cls.impl = 1'b1;
			end
			`DEC_OP_LOAD: begin
				cls.load = 1'b1;
				cls.impl = 1'b1;
			end
			`DEC_OP_STORE: begin
				cls.store = 1'b1;
				cls.impl  = 1'b1;
			end
			// Flow control
			`DEC_OP_BCC: begin
				cls.br   = 1'b1;
				cls.impl = 1'b1;
			end
			`DEC_OP_JSR: begin
				cls.jsr  = 1'b1;
				cls.impl = 1'b1;
			end
			`DEC_OP_BSR: begin
				cls.bsr  = 1'b1;
				cls.impl = 1'b1;
			end
			`DEC_OP_FENCE: begin
				cls.fence = 1'b1;
				cls.impl  = 1'b1;
			end
			`DEC_OP_FADD: begin
				cls.fpu  = 1'b1;
				cls.impl = 1'b1;
			end
			`DEC_OP_ERET: begin
				cls.eret = 1'b1;
				cls.impl = 1'b1;
			end
			`DEC_OP_SYS: begin
				cls.sys  = 1'b1;
				cls.impl = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/insn_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module insn_decoder (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        en,
	input  decode_pkg::pc_address_t     ip,
	input  decode_pkg::operating_mode_t om,
	input  decode_pkg::micro_op_t       instr,
	output decode_pkg::decode_bus_t     dbo
);

	// Combinational decode of the current micro-op
	decode_pkg::decode_bus_t db;

	// Sub-decoder outputs
	decode_pkg::imm_t        imm;
	logic                    has_imm;
	logic                    has_immb;
	decode_pkg::reg_num_t    rd;
	decode_pkg::reg_num_t    rs1;
	decode_pkg::reg_num_t    rs2;
	logic                    rdz;
	logic                    rs1z;
	logic                    rs2z;
	logic                    exc;
	decode_pkg::unit_class_t cls;

	// ========================================
	// Sub-decoders
	// ========================================

	decode_imm u_imm (
		.instr    (instr),
		.imm      (imm),
		.has_imm  (has_imm),
		.has_immb (has_immb)
	);

	// Needs has_immb so Rs2 is neither reported nor checked under an immediate
	decode_regs u_regs (
		.om       (om),
		.instr    (instr),
		.has_immb (has_immb),
		.Rd       (rd),
		.Rs1      (rs1),
		.Rs2      (rs2),
		.Rdz      (rdz),
		.Rs1z     (rs1z),
		.Rs2z     (rs2z),
		.exc      (exc)
	);

	decode_class u_class (
		.instr (instr),
		.cls   (cls)
	);

	// ========================================
	// Bus assembly
	// ========================================

	always_comb begin
		db          = '0;
		db.v        = instr.v;
		db.Rd       = rd;
		db.Rs1      = rs1;
		db.Rs2      = rs2;
		db.Rdz      = rdz;
		db.Rs1z     = rs1z;
		db.Rs2z     = rs2z;
		db.has_imm  = has_imm;
		db.has_immb = has_immb;
		db.imm      = imm;
		db.cls      = cls;
		db.mem      = cls.load | cls.store;
		// A fence with all function bits set waits for everything, not just memory
		db.sync     = cls.fence && (instr.func == `DEC_FUNC_W'(`DEC_SYNC_FUNC));
		db.rc       = instr.func[`DEC_FUNC_W-1];
		db.ip       = ip;
		// A bad register wins over an unimplemented opcode
		if (exc) begin
			db.cause = decode_pkg::FLT_BADREG;
		end else if (!cls.impl) begin
			db.cause = decode_pkg::FLT_UNIMP;
		end else begin
			db.cause = decode_pkg::FLT_NONE;
		end
		// Dead slot, turn it into a harmless nop on the ALU with no fault
		if (!instr.v) begin
			db         = '0;
			db.cls.nop = 1'b1;
			db.cls.alu = 1'b1;
			db.cause   = decode_pkg::FLT_NONE;
		end
	end

	// ========================================
	// Output register
	// ========================================

	// The stage only moves when en is high, otherwise dbo holds
	always_ff @(posedge clk) begin
		if (rst) begin
			dbo         <= '0;
			dbo.cls.nop <= 1'b1;
			dbo.cls.alu <= 1'b1;
			dbo.Rdz     <= 1'b1;
			dbo.cause   <= decode_pkg::FLT_NONE;
		end else if (en) begin
			dbo <= db;
		end
	end

endmodule

`default_nettype wire

// ==== tests/insn_decoder_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module insn_decoder_properties (
	input logic                    clk,
	input logic                    rst,
	input logic                    en,
	input decode_pkg::decode_bus_t dbo
);

	// ========================================
	// Reset and stall behavior
	// ========================================

	// The reset value of the decode bus never carries a live micro-op
	reset_clears_valid: assert property (
		@(posedge clk) rst |=> !dbo.v
	) else $error("dbo.v is set in the cycle after reset");

	// A stalled stage keeps the bus exactly as it was
	stall_holds_bus: assert property (
		@(posedge clk) disable iff (rst)
		!en |=> $stable(dbo)
	) else $error("dbo changed after a cycle with en low");

	// ========================================
	// Bus consistency
	// ========================================

	// An opcode from the table cannot be reported as unimplemented
	impl_not_unimp: assert property (
		@(posedge clk) disable iff (rst)
		dbo.cls.impl |-> (dbo.cause != decode_pkg::FLT_UNIMP)
	) else $error("cause is FLT_UNIMP while impl is set");

	// Only a bubble has nop and alu together, and a bubble is never valid
	no_valid_bubble: assert property (
		@(posedge clk) disable iff (rst)
		!(dbo.v && dbo.cls.nop && dbo.cls.alu)
	) else $error("bubble pattern seen with v set");

endmodule

`default_nettype wire

// ==== tests/insn_decoder_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module insn_decoder_tb;

	localparam int NUM_RANDOM = 200;

	// Class flag masks in unit_class_t order, nop on top and impl in bit 0
	localparam logic [16:0] F_NOP   = 17'h10000;
	localparam logic [16:0] F_ALU   = 17'h08000;
	localparam logic [16:0] F_BIT   = 17'h04000;
	localparam logic [16:0] F_MUL   = 17'h02000;
	localparam logic [16:0] F_MULU  = 17'h01000;
	localparam logic [16:0] F_DIV   = 17'h00800;
	localparam logic [16:0] F_DIVU  = 17'h00400;
	localparam logic [16:0] F_LOAD  = 17'h00200;
	localparam logic [16:0] F_STORE = 17'h00100;
	localparam logic [16:0] F_BR    = 17'h00080;
	localparam logic [16:0] F_JSR   = 17'h00040;
	localparam logic [16:0] F_BSR   = 17'h00020;
	localparam logic [16:0] F_FENCE = 17'h00010;
	localparam logic [16:0] F_FPU   = 17'h00008;
	localparam logic [16:0] F_ERET  = 17'h00004;
	localparam logic [16:0] F_SYS   = 17'h00002;
	localparam logic [16:0] F_IMPL  = 17'h00001;

	// One directed row: inputs, then the values expected on dbo a cycle later
	typedef struct packed {
		decode_pkg::operating_mode_t om;
		decode_pkg::micro_op_t       instr;
		logic                        en;
		decode_pkg::unit_class_t     cls;
		decode_pkg::fault_cause_t    cause;
		decode_pkg::imm_t            imm;
	} table_row_t;

	logic                        clk;
	logic                        rst;
	logic                        en;
	decode_pkg::pc_address_t     ip;
	decode_pkg::operating_mode_t om;
	decode_pkg::micro_op_t       instr;
	decode_pkg::decode_bus_t     dbo;

	table_row_t              rows[$];
	decode_pkg::decode_bus_t exp_bus;
	int                      checks = 0;
	int                      errors = 0;
	int                      cycles = 0;
	int                      cycle_limit = 0;

	// Implemented opcodes, random stimulus picks from here most of the time
	decode_pkg::opcode_t known_ops [19] = '{
		`DEC_OP_NOP, `DEC_OP_ADD, `DEC_OP_ADDI, `DEC_OP_AND, `DEC_OP_OR,
		`DEC_OP_XOR, `DEC_OP_MUL, `DEC_OP_MULU, `DEC_OP_DIV, `DEC_OP_DIVU,
		`DEC_OP_LOAD, `DEC_OP_STORE, `DEC_OP_BCC, `DEC_OP_JSR, `DEC_OP_BSR,
		`DEC_OP_FENCE, `DEC_OP_FADD, `DEC_OP_ERET, `DEC_OP_SYS
	};

	insn_decoder dut (
		.clk   (clk),
		.rst   (rst),
		.en    (en),
		.ip    (ip),
		.om    (om),
		.instr (instr),
		.dbo   (dbo)
	);

	bind insn_decoder insn_decoder_properties props (
		.clk (clk),
		.rst (rst),
		.en  (en),
		.dbo (dbo)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Watchdog, the limit is set once the table is known
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ========================================
	// Stimulus helpers
	// ========================================

	function automatic decode_pkg::micro_op_t make_op(input logic v,
			input decode_pkg::opcode_t opc, input decode_pkg::reg_num_t rd,
			input decode_pkg::reg_num_t rs1, input decode_pkg::reg_num_t rs2,
			input decode_pkg::func_t func);
		decode_pkg::micro_op_t op;
		op.v      = v;
		op.opcode = opc;
		op.rd     = rd;
		op.rs1    = rs1;
		op.rs2    = rs2;
		op.func   = func;
		return op;
	endfunction

	task automatic add_row(input decode_pkg::operating_mode_t m, input decode_pkg::micro_op_t op,
			input logic e, input logic [16:0] flags, input decode_pkg::fault_cause_t c,
			input decode_pkg::imm_t value);
		table_row_t r;
		r.om    = m;
		r.instr = op;
		r.en    = e;
		r.cls   = flags;
		r.cause = c;
		r.imm   = value;
		rows.push_back(r);
	endtask

	function automatic decode_pkg::micro_op_t random_op();
		decode_pkg::micro_op_t op;
		logic [4:0]            k;
		op.v = ($urandom_range(0, 7) != 0);
		if ($urandom_range(0, 3) != 0) begin
			k         = 5'($urandom_range(0, 18));
			op.opcode = known_ops[k];
		end else begin
			op.opcode = 7'($urandom_range(0, 127));
		end
		op.rd   = 6'($urandom_range(0, 63));
		op.rs1  = 6'($urandom_range(0, 63));
		op.rs2  = 6'($urandom_range(0, 63));
		op.func = 7'($urandom_range(0, 127));
		return op;
	endfunction

	// ========================================
	// Reference model of the decode rules
	// ========================================

	function automatic decode_pkg::decode_bus_t model_decode(
			input decode_pkg::operating_mode_t m, input decode_pkg::micro_op_t mi,
			input decode_pkg::pc_address_t pc);
		decode_pkg::decode_bus_t b;
		logic [16:0]             flags;
		logic                    imm_op;
		logic                    chk_rd;
		logic                    chk_rs1;
		logic                    chk_rs2;
		logic                    bad;
		int                      limit;
		b = '0;
		case (mi.opcode)
			`DEC_OP_NOP:   flags = F_NOP | F_IMPL;
			`DEC_OP_ADD:   flags = F_ALU | F_IMPL;
			`DEC_OP_ADDI:  flags = F_ALU | F_IMPL;
			`DEC_OP_AND:   flags = F_ALU | F_BIT | F_IMPL;
			`DEC_OP_OR:    flags = F_ALU | F_BIT | F_IMPL;
			`DEC_OP_XOR:   flags = F_ALU | F_BIT | F_IMPL;
			`DEC_OP_MUL:   flags = F_ALU | F_MUL | F_IMPL;
			`DEC_OP_MULU:  flags = F_ALU | F_MULU | F_IMPL;
			`DEC_OP_DIV:   flags = F_ALU | F_DIV | F_IMPL;
			`DEC_OP_DIVU:  flags = F_ALU | F_DIVU | F_IMPL;
			`DEC_OP_LOAD:  flags = F_LOAD | F_IMPL;
			`DEC_OP_STORE: flags = F_STORE | F_IMPL;
			`DEC_OP_BCC:   flags = F_BR | F_IMPL;
			`DEC_OP_JSR:   flags = F_JSR | F_IMPL;
			`DEC_OP_BSR:   flags = F_BSR | F_IMPL;
			`DEC_OP_FENCE: flags = F_FENCE | F_IMPL;
			`DEC_OP_FADD:  flags = F_FPU | F_IMPL;
			`DEC_OP_ERET:  flags = F_ERET | F_IMPL;
			`DEC_OP_SYS:   flags = F_SYS | F_IMPL;
			default:       flags = '0;
		endcase
		imm_op = (mi.opcode == `DEC_OP_ADDI) || (mi.opcode == `DEC_OP_LOAD) ||
			(mi.opcode == `DEC_OP_STORE) || (mi.opcode == `DEC_OP_BCC) ||
			(mi.opcode == `DEC_OP_FENCE);
		case (m)
			decode_pkg::MODE_USER: limit = `DEC_USER_REG_LIMIT;
			decode_pkg::MODE_SUPV: limit = `DEC_SUPV_REG_LIMIT;
			default:               limit = 1 << `DEC_REG_W;
		endcase
		// NOP, ERET and SYS read no registers, BCC and STORE write none
		chk_rd  = !(mi.opcode inside {`DEC_OP_NOP, `DEC_OP_ERET, `DEC_OP_SYS,
			`DEC_OP_BCC, `DEC_OP_STORE});
		chk_rs1 = !(mi.opcode inside {`DEC_OP_NOP, `DEC_OP_ERET, `DEC_OP_SYS});
		chk_rs2 = chk_rs1 && !imm_op;
		bad = (chk_rd && int'(mi.rd) >= limit) || (chk_rs1 && int'(mi.rs1) >= limit) ||
			(chk_rs2 && int'(mi.rs2) >= limit);
		b.v        = 1'b1;
		b.Rd       = mi.rd;
		b.Rs1      = mi.rs1;
		b.Rs2      = imm_op ? '0 : mi.rs2;
		b.Rdz      = (b.Rd == 6'd0);
		b.Rs1z     = (b.Rs1 == 6'd0);
		b.Rs2z     = (b.Rs2 == 6'd0);
		b.has_imm  = imm_op;
		b.has_immb = imm_op;
		if (imm_op) begin
			b.imm = {{(`DEC_DATA_W-`DEC_FUNC_W-`DEC_REG_W){mi.func[`DEC_FUNC_W-1]}},
				mi.func, mi.rs2};
		end
		b.cls  = flags;
		b.mem  = b.cls.load || b.cls.store;
		b.sync = b.cls.fence && (mi.func == 7'(`DEC_SYNC_FUNC));
		b.rc   = mi.func[`DEC_FUNC_W-1];
		b.ip   = pc;
		if (bad) begin
			b.cause = decode_pkg::FLT_BADREG;
		end else if (!b.cls.impl) begin
			b.cause = decode_pkg::FLT_UNIMP;
		end else begin
			b.cause = decode_pkg::FLT_NONE;
		end
		// An empty slot is a bubble, nop on the ALU and nothing else
		if (!mi.v) begin
			b       = '0;
			b.cls   = F_NOP | F_ALU;
			b.cause = decode_pkg::FLT_NONE;
		end
		return b;
	endfunction

	// ========================================
	// Checks
	// ========================================

	task automatic compare_field(input string name, input logic [63:0] got,
			input logic [63:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
		end
	endtask

	task automatic check_bus(input decode_pkg::decode_bus_t want);
		compare_field("v", 64'(dbo.v), 64'(want.v));
		compare_field("Rd", 64'(dbo.Rd), 64'(want.Rd));
		compare_field("Rs1", 64'(dbo.Rs1), 64'(want.Rs1));
		compare_field("Rs2", 64'(dbo.Rs2), 64'(want.Rs2));
		compare_field("Rdz", 64'(dbo.Rdz), 64'(want.Rdz));
		compare_field("Rs1z", 64'(dbo.Rs1z), 64'(want.Rs1z));
		compare_field("Rs2z", 64'(dbo.Rs2z), 64'(want.Rs2z));
		compare_field("has_imm", 64'(dbo.has_imm), 64'(want.has_imm));
		compare_field("has_immb", 64'(dbo.has_immb), 64'(want.has_immb));
		compare_field("imm", dbo.imm, want.imm);
		compare_field("cls", 64'(dbo.cls), 64'(want.cls));
		compare_field("mem", 64'(dbo.mem), 64'(want.mem));
		compare_field("sync", 64'(dbo.sync), 64'(want.sync));
		compare_field("rc", 64'(dbo.rc), 64'(want.rc));
		compare_field("ip", 64'(dbo.ip), 64'(want.ip));
		compare_field("cause", 64'(dbo.cause), 64'(want.cause));
	endtask

	// ========================================
	// Directed table
	// ========================================

	task automatic load_table();
		decode_pkg::operating_mode_t u;
		decode_pkg::operating_mode_t s;
		decode_pkg::operating_mode_t mm;
		decode_pkg::fault_cause_t    ok;
		u  = decode_pkg::MODE_USER;
		s  = decode_pkg::MODE_SUPV;
		mm = decode_pkg::MODE_MACH;
		ok = decode_pkg::FLT_NONE;
		// Every implemented opcode with legal registers
		add_row(u, make_op(1, `DEC_OP_NOP, 6'd3, 6'd4, 6'd5, 7'd0), 1, F_NOP | F_IMPL, ok, 64'd0);
		add_row(u, make_op(1, `DEC_OP_ADD, 6'd3, 6'd4, 6'd5, 7'd0), 1, F_ALU | F_IMPL, ok, 64'd0);
		add_row(u, make_op(1, `DEC_OP_ADDI, 6'd3, 6'd4, 6'd5, 7'd0), 1, F_ALU | F_IMPL, ok, 64'd5);
		add_row(u, make_op(1, `DEC_OP_AND, 6'd3, 6'd4, 6'd5, 7'd0), 1, F_ALU | F_BIT | F_IMPL, ok, 64'd0);
		add_row(u, make_op(1, `DEC_OP_OR, 6'd3, 6'd4, 6'd5, 7'd0), 1, F_ALU | F_BIT | F_IMPL, ok, 64'd0);
		add_row(u, make_op(1, `DEC_OP_XOR, 6'd3, 6'd4, 6'd5, 7'd0), 1, F_ALU | F_BIT | F_IMPL, ok, 64'd0);
		add_row(u, make_op(1, `DEC_OP_MUL, 6'd3, 6'd4, 6'd5, 7'd0), 1, F_ALU | F_MUL | F_IMPL, ok, 64'd0);
		add_row(u, make_op(1, `DEC_OP_MULU, 6'd3, 6'd4, 6'd5, 7'd0), 1, F_ALU | F_MULU | F_IMPL, ok, 64'd0);
		add_row(u, make_op(1, `DEC_OP_DIV, 6'd3, 6'd4, 6'd5, 7'd0), 1, F_ALU | F_DIV | F_IMPL, ok, 64'd0);
		add_row(u, make_op(1, `DEC_OP_DIVU, 6'd3, 6'd4, 6'd5, 7'd0), 1, F_ALU | F_DIVU | F_IMPL, ok, 64'd0);
		add_row(u, make_op(1, `DEC_OP_LOAD, 6'd3, 6'd4, 6'd6, 7'd0), 1, F_LOAD | F_IMPL, ok, 64'd6);
		add_row(u, make_op(1, `DEC_OP_STORE, 6'd3, 6'd4, 6'd7, 7'd0), 1, F_STORE | F_IMPL, ok, 64'd7);
		add_row(u, make_op(1, `DEC_OP_BCC, 6'd3, 6'd4, 6'd2, 7'd0), 1, F_BR | F_IMPL, ok, 64'd2);
		add_row(u, make_op(1, `DEC_OP_JSR, 6'd3, 6'd4, 6'd5, 7'd0), 1, F_JSR | F_IMPL, ok, 64'd0);
		add_row(u, make_op(1, `DEC_OP_BSR, 6'd3, 6'd4, 6'd5, 7'd0), 1, F_BSR | F_IMPL, ok, 64'd0);
		add_row(u, make_op(1, `DEC_OP_FENCE, 6'd3, 6'd4, 6'd1, 7'd0), 1, F_FENCE | F_IMPL, ok, 64'd1);
		// Function field of all ones turns the fence into a sync, imm is then -1
		add_row(u, make_op(1, `DEC_OP_FENCE, 6'd3, 6'd4, 6'd63, 7'd127), 1, F_FENCE | F_IMPL, ok,
			64'hFFFF_FFFF_FFFF_FFFF);
		add_row(u, make_op(1, `DEC_OP_FADD, 6'd3, 6'd4, 6'd5, 7'd0), 1, F_FPU | F_IMPL, ok, 64'd0);
		add_row(u, make_op(1, `DEC_OP_ERET, 6'd3, 6'd4, 6'd5, 7'd0), 1, F_ERET | F_IMPL, ok, 64'd0);
		add_row(u, make_op(1, `DEC_OP_SYS, 6'd3, 6'd4, 6'd5, 7'd0), 1, F_SYS | F_IMPL, ok, 64'd0);
		// Opcodes outside the table
		add_row(u, make_op(1, 7'd6, 6'd3, 6'd4, 6'd5, 7'd0), 1, 17'h0, decode_pkg::FLT_UNIMP, 64'd0);
		add_row(u, make_op(1, 7'd50, 6'd3, 6'd4, 6'd5, 7'd0), 1, 17'h0, decode_pkg::FLT_UNIMP, 64'd0);
		add_row(mm, make_op(1, 7'd127, 6'd3, 6'd4, 6'd5, 7'd0), 1, 17'h0, decode_pkg::FLT_UNIMP, 64'd0);
		// Negative and large immediates
		add_row(u, make_op(1, `DEC_OP_LOAD, 6'd3, 6'd4, 6'd56, 7'd127), 1, F_LOAD | F_IMPL, ok,
			64'hFFFF_FFFF_FFFF_FFF8);
		add_row(u, make_op(1, `DEC_OP_STORE, 6'd3, 6'd4, 6'd63, 7'd63), 1, F_STORE | F_IMPL, ok,
			64'h0000_0000_0000_0FFF);
		// Register limits per mode
		add_row(u, make_op(1, `DEC_OP_ADD, 6'd3, 6'd50, 6'd5, 7'd0), 1, F_ALU | F_IMPL,
			decode_pkg::FLT_BADREG, 64'd0);
		add_row(mm, make_op(1, `DEC_OP_ADD, 6'd3, 6'd50, 6'd5, 7'd0), 1, F_ALU | F_IMPL, ok, 64'd0);
		add_row(s, make_op(1, `DEC_OP_ADD, 6'd57, 6'd4, 6'd5, 7'd0), 1, F_ALU | F_IMPL,
			decode_pkg::FLT_BADREG, 64'd0);
		add_row(s, make_op(1, `DEC_OP_ADD, 6'd50, 6'd4, 6'd5, 7'd0), 1, F_ALU | F_IMPL, ok, 64'd0);
		add_row(u, make_op(1, `DEC_OP_STORE, 6'd60, 6'd4, 6'd0, 7'd0), 1, F_STORE | F_IMPL, ok, 64'd0);
		add_row(u, make_op(1, `DEC_OP_ADDI, 6'd3, 6'd4, 6'd55, 7'd0), 1, F_ALU | F_IMPL, ok, 64'd55);
		add_row(u, make_op(1, `DEC_OP_NOP, 6'd63, 6'd63, 6'd63, 7'd0), 1, F_NOP | F_IMPL, ok, 64'd0);
		add_row(u, make_op(1, 7'd6, 6'd3, 6'd50, 6'd5, 7'd0), 1, 17'h0, decode_pkg::FLT_BADREG, 64'd0);
		add_row(u, make_op(1, `DEC_OP_ADD, 6'd0, 6'd0, 6'd0, 7'd0), 1, F_ALU | F_IMPL, ok, 64'd0);
		// Stall holds the previous result, then an empty slot becomes a bubble
		add_row(u, make_op(1, `DEC_OP_ADDI, 6'd3, 6'd4, 6'd0, 7'd64), 1, F_ALU | F_IMPL, ok,
			64'hFFFF_FFFF_FFFF_F000);
		add_row(u, make_op(1, `DEC_OP_XOR, 6'd3, 6'd4, 6'd5, 7'd0), 0, F_ALU | F_IMPL, ok,
			64'hFFFF_FFFF_FFFF_F000);
		add_row(u, make_op(0, `DEC_OP_ADD, 6'd3, 6'd4, 6'd5, 7'd0), 1, F_NOP | F_ALU, ok, 64'd0);
		add_row(u, make_op(1, `DEC_OP_MUL, 6'd3, 6'd4, 6'd5, 7'd0), 0, F_NOP | F_ALU, ok, 64'd0);
		add_row(u, make_op(1, `DEC_OP_ADD, 6'd1, 6'd2, 6'd3, 7'd0), 1, F_ALU | F_IMPL, ok, 64'd0);
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		int unsigned                 seed_ret;
		table_row_t                  r;
		decode_pkg::micro_op_t       op;
		decode_pkg::operating_mode_t m;
		decode_pkg::pc_address_t     pc;
		rst      = 1'b1;
		en       = 1'b0;
		ip       = '0;
		om       = decode_pkg::MODE_USER;
		instr    = '0;
		seed_ret = $urandom(18387);
		load_table();
		// Two cycles per applied micro-op plus room for reset
		cycle_limit = 2 * rows.size() + 2 * NUM_RANDOM + 20;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		// Reset value, nop and alu with Rdz and nothing live
		exp_bus         = '0;
		exp_bus.cls.nop = 1'b1;
		exp_bus.cls.alu = 1'b1;
		exp_bus.Rdz     = 1'b1;
		exp_bus.cause   = decode_pkg::FLT_NONE;
		check_bus(exp_bus);
		for (int i = 0; i < rows.size(); i++) begin
			@(posedge clk);
			r     = rows[i];
			pc    = 32'h0000_1000 + 32'(i) * 32'd4;
			om    <= r.om;
			instr <= r.instr;
			en    <= r.en;
			ip    <= pc;
			if (r.en) begin
				exp_bus = model_decode(r.om, r.instr, pc);
			end
			@(posedge clk);
			@(negedge clk);
			check_bus(exp_bus);
			compare_field("table cls", 64'(dbo.cls), 64'(r.cls));
			compare_field("table cause", 64'(dbo.cause), 64'(r.cause));
			compare_field("table imm", dbo.imm, r.imm);
		end
		for (int i = 0; i < NUM_RANDOM; i++) begin
			@(posedge clk);
			op    = random_op();
			m     = decode_pkg::operating_mode_t'(2'($urandom_range(0, 2)));
			pc    = 32'($urandom);
			om    <= m;
			instr <= op;
			en    <= 1'b1;
			ip    <= pc;
			exp_bus = model_decode(m, op, pc);
			@(posedge clk);
			@(negedge clk);
			check_bus(exp_bus);
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== insn_decoder.f ====
+incdir+hdl
hdl/decode_pkg.sv
hdl/decode_imm.sv
hdl/decode_regs.sv
hdl/decode_class.sv
hdl/insn_decoder.sv
tests/insn_decoder_properties.sv
tests/insn_decoder_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
SIM_FLAGS  = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = insn_decoder_tb
FILELIST   = insn_decoder.f
OBJ_DIR    = obj_dir
PASS_MSG   = TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only when the pass line shows up in the simulator output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
